//--- Bender.yml
package:
  name: mcpu

sources:
  - mcpu_pkg.sv
  - mcpu_decode_if.sv
  - mcpu_result_if.sv
  - mcpu_regfile.sv
  - mcpu_sequencer.sv
  - mcpu_execute.sv
  - mcpu_bus.sv
  - mcpu_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - mcpu_tb.sv

//--- mcpu.f
mcpu_pkg.sv
mcpu_decode_if.sv
mcpu_result_if.sv
mcpu_regfile.sv
mcpu_sequencer.sv
mcpu_execute.sv
mcpu_bus.sv
mcpu_top.sv
tb_clock_gen.sv
mcpu_tb.sv

//--- mcpu_bus.sv
`default_nettype none
`timescale 1ns/1ps

module mcpu_bus
    import mcpu_pkg::*;
(
    mcpu_decode_if.bus dec,
    mcpu_result_if.bus res,
    output word_t      address,
    output word_t      data_out,
    output logic       mem_write
);

    logic store_cycle;

    assign store_cycle = dec.exec && (dec.opcode == OP_STORE);

    // instruction fetch address unless a store owns the bus
    always_comb
    begin
        if (store_cycle)
        begin
            address = res.store_addr;
        end
        else
        begin
            address = dec.pc;
        end
    end

    assign mem_write = store_cycle;
    assign data_out  = res.store_data;

endmodule

`default_nettype wire

//--- mcpu_decode_if.sv
`default_nettype none
`timescale 1ns/1ps

interface mcpu_decode_if
    import mcpu_pkg::*;
();

    opcode_t  opcode;
    reg_idx_t ra;
    reg_idx_t rb;
    reg_idx_t rd;
    logic     hl;
    imm_t     imm;
    // high for the single execute cycle of each instruction
    logic     exec;
    word_t    pc;

    modport sequencer (
        output opcode, ra, rb, rd, hl, imm, exec, pc
    );

    modport execute (
        input opcode, ra, rb, rd, hl, imm, exec
    );

    modport bus (
        input opcode, exec, pc
    );

endinterface

`default_nettype wire

//--- mcpu_execute.sv
`default_nettype none
`timescale 1ns/1ps

module mcpu_execute
    import mcpu_pkg::*;
(
    input  logic clock,
    input  logic rst_n,
    mcpu_decode_if.execute dec,
    mcpu_result_if.execute res
);

    reg_idx_t port_a_idx;
    word_t    val_a;
    word_t    val_b;
    logic     flag_a;
    word_t    alu_res;
    logic     writes_rd;
    logic     wr_en;
    logic     is_ldi;

    assign is_ldi = (dec.opcode == OP_LDI);

    // LDI needs the old rd so the untouched half survives
    assign port_a_idx = is_ldi ? dec.rd : dec.ra;

    mcpu_regfile u_regfile (
        .clock   (clock),
        .rst_n   (rst_n),
        .rd_a    (port_a_idx),
        .rd_b    (dec.rb),
        .val_a   (val_a),
        .val_b   (val_b),
        .flag_a  (flag_a),
        .wr_en   (wr_en),
        .wr_idx  (dec.rd),
        .wr_val  (alu_res),
        .wr_flag (alu_res == '0)
    );

    always_comb
    begin
        alu_res   = '0;
        writes_rd = 1'b1;
        case (dec.opcode)
            OP_ADD:
            begin
                alu_res = val_a + val_b;
            end
            OP_SUB:
            begin
                alu_res = val_a - val_b;
            end
            OP_AND:
            begin
                alu_res = val_a & val_b;
            end
            OP_OR:
            begin
                alu_res = val_a | val_b;
            end
            OP_XOR:
            begin
                alu_res = val_a ^ val_b;
            end
            OP_LDI:
            begin
                // hl picks which half takes the immediate
                if (dec.hl)
                begin
                    alu_res = {dec.imm, val_a[15:0]};
                end
                else
                begin
                    alu_res = {val_a[31:16], dec.imm};
                end
            end
            default:
            begin
                // store, branch and unknown opcodes leave the registers alone
                writes_rd = 1'b0;
            end
        endcase
    end

    assign wr_en = dec.exec && writes_rd;

    // held through advance since nothing is written for BRF
    assign res.branch_taken = (dec.opcode == OP_BRF) && flag_a;
    assign res.target       = {16'h0000, dec.imm};
    assign res.store_addr   = val_a;
    assign res.store_data   = val_b;

endmodule

`default_nettype wire

//--- mcpu_pkg.sv
`default_nettype none

package mcpu_pkg;

    localparam int unsigned NUM_REGS = 8;

    // instruction word layout
    localparam int unsigned OPC_LSB = 0;
    localparam int unsigned OPC_MSB = 5;
    localparam int unsigned RA_LSB  = 6;
    localparam int unsigned RA_MSB  = 8;
    localparam int unsigned RB_LSB  = 9;
    localparam int unsigned RB_MSB  = 11;
    localparam int unsigned RD_LSB  = 12;
    localparam int unsigned RD_MSB  = 14;
    localparam int unsigned HL_BIT  = 15;
    localparam int unsigned IMM_LSB = 16;
    localparam int unsigned IMM_MSB = 31;

    typedef logic [31:0]                   word_t;
    typedef logic [$clog2(NUM_REGS)-1:0]   reg_idx_t;
    typedef logic [OPC_MSB-OPC_LSB:0]      opcode_t;
    typedef logic [IMM_MSB-IMM_LSB:0]      imm_t;

    localparam word_t RESET_PC = 32'h0000_0000;

    // opcodes not listed here execute as no-ops
    typedef enum opcode_t {
        OP_ADD   = 6'd1,
        OP_SUB   = 6'd2,
        OP_AND   = 6'd3,
        OP_OR    = 6'd4,
        OP_XOR   = 6'd5,
        OP_LDI   = 6'd6,
        OP_STORE = 6'd7,
        OP_BRF   = 6'd8
    } op_e;

    typedef enum logic [1:0] {
        PH_FETCH   = 2'd0,
        PH_EXECUTE = 2'd1,
        PH_ADVANCE = 2'd2
    } phase_e;

endpackage

`default_nettype wire

//--- mcpu_regfile.sv
`default_nettype none
`timescale 1ns/1ps

module mcpu_regfile
    import mcpu_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  reg_idx_t rd_a,
    input  reg_idx_t rd_b,
    output word_t    val_a,
    output word_t    val_b,
    output logic     flag_a,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_val,
    input  logic     wr_flag
);

    word_t               regs  [NUM_REGS];
    logic [NUM_REGS-1:0] flags;

    // word and flag always written together
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else if (wr_en)
        begin
            regs[wr_idx]  <= wr_val;
            flags[wr_idx] <= wr_flag;
        end
    end

    // asynchronous reads
    assign val_a  = regs[rd_a];
    assign val_b  = regs[rd_b];
    assign flag_a = flags[rd_a];

    a_wr_known: assert property (
        @(posedge clock) disable iff (!rst_n)
        wr_en |-> !$isunknown({wr_idx, wr_val, wr_flag})
    );

endmodule

`default_nettype wire

//--- mcpu_result_if.sv
`default_nettype none
`timescale 1ns/1ps

interface mcpu_result_if
    import mcpu_pkg::*;
();

    logic  branch_taken;
    word_t target;
    word_t store_addr;
    word_t store_data;

    modport execute (
        output branch_taken, target, store_addr, store_data
    );

    modport sequencer (
        input branch_taken, target
    );

    modport bus (
        input store_addr, store_data
    );

endinterface

`default_nettype wire

//--- mcpu_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module mcpu_sequencer
    import mcpu_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  word_t data_in,
    mcpu_decode_if.sequencer dec,
    mcpu_result_if.sequencer res
);

    phase_e phase;
    phase_e phase_next;
    word_t  pc;
    word_t  ir;

    // fetch -> execute -> advance, one cycle each
    always_comb
    begin
        case (phase)
            PH_FETCH:   phase_next = PH_EXECUTE;
            PH_EXECUTE: phase_next = PH_ADVANCE;
            default:    phase_next = PH_FETCH;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            phase <= PH_FETCH;
        end
        else
        begin
            phase <= phase_next;
        end
    end

    // instruction register, cleared to a no-op
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ir <= '0;
        end
        else if (phase == PH_FETCH)
        begin
            ir <= data_in;
        end
    end

    // pc moves only as advance closes
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc <= RESET_PC;
        end
        else if (phase == PH_ADVANCE)
        begin
            if (res.branch_taken)
            begin
                pc <= res.target;
            end
            else
            begin
                pc <= pc + 32'd1;
            end
        end
    end

    // field split
    assign dec.opcode = ir[OPC_MSB:OPC_LSB];
    assign dec.ra     = ir[RA_MSB:RA_LSB];
    assign dec.rb     = ir[RB_MSB:RB_LSB];
    assign dec.rd     = ir[RD_MSB:RD_LSB];
    assign dec.hl     = ir[HL_BIT];
    assign dec.imm    = ir[IMM_MSB:IMM_LSB];
    assign dec.exec   = (phase == PH_EXECUTE);
    assign dec.pc     = pc;

    a_phase_legal: assert property (
        @(posedge clock) disable iff (!rst_n)
        phase inside {PH_FETCH, PH_EXECUTE, PH_ADVANCE}
    );

    // branch target is consumed one phase after execute
    a_pc_stable: assert property (
        @(posedge clock) disable iff (!rst_n)
        (phase != PH_ADVANCE) |=> $stable(pc)
    );

endmodule

`default_nettype wire

//--- mcpu_tb.sv
`default_nettype none
`timescale 1ns/1ps

module mcpu_tb
    import mcpu_pkg::*;
();

    localparam int CLK_PERIOD_NS = 20;
    localparam int RESET_CYCLES  = 5;
    localparam int NUM_INSTR     = 400;
    localparam int PROG_WORDS    = 64;
    localparam int TIMEOUT_NS    = (RESET_CYCLES + 3 * NUM_INSTR) * CLK_PERIOD_NS + 2000;

    logic  clock;
    logic  rst_n;
    word_t data_in;
    word_t address;
    word_t data_out;
    logic  mem_write;

    word_t prog [PROG_WORDS];

    // reference model state
    word_t      m_regs [NUM_REGS];
    logic [7:0] m_flags;
    word_t      m_pc;

    integer seed = 32'hd1b8;
    int     error_count = 0;
    int     n_store = 0;
    int     n_taken = 0;
    int     n_not_taken = 0;

    tb_clock_gen u_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    mcpu_top uut (
        .clock     (clock),
        .rst_n     (rst_n),
        .data_in   (data_in),
        .address   (address),
        .data_out  (data_out),
        .mem_write (mem_write)
    );

    initial
    begin
        data_in = '0;
    end

    // program memory answers on address changes and is refreshed after each edge
    always @(posedge clock)
    begin
        #1;
        data_in = prog[address[5:0]];
    end

    always @(address)
    begin
        data_in = prog[address[5:0]];
    end

    task automatic compare_word(input word_t actual, input word_t expected, input string what);
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, actual, expected);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic write_reg(input logic [2:0] idx, input word_t val);
        m_regs[idx]  = val;
        m_flags[idx] = (val == 32'd0);
    endtask

    task automatic fill_program();
        int    pick;
        word_t instr;
        for (int i = 0; i < PROG_WORDS; i++)
        begin
            instr = $random(seed);
            pick  = $unsigned($random(seed)) % 12;
            if (pick < 8)
            begin
                instr[5:0] = pick + 1;
            end
            else if (pick < 10)
            begin
                instr[5:0] = OP_LDI;
            end
            else
            begin
                // undefined: 0 or 9..63
                pick = $unsigned($random(seed)) % 56;
                instr[5:0] = (pick == 0) ? 6'd0 : pick + 8;
            end
            // forward hops keep the program out of tight loops
            if (instr[5:0] == OP_BRF)
            begin
                instr[31:16] = (i + 2 + $unsigned($random(seed)) % 6) % PROG_WORDS;
            end
            prog[i] = instr;
        end
    endtask

    initial
    begin
        word_t       instr;
        word_t       next_pc;
        logic [5:0]  opc;
        logic [2:0]  ra;
        logic [2:0]  rb;
        logic [2:0]  rd;
        logic        hl;
        logic [15:0] imm;

        fill_program();
        for (int i = 0; i < NUM_REGS; i++)
        begin
            m_regs[i] = '0;
        end
        m_flags = '0;
        m_pc    = '0;

        @(negedge clock);
        compare_word(mem_write, 32'd0, "mem_write during reset");
        wait (rst_n === 1'b1);

        for (int n = 0; n < NUM_INSTR; n++)
        begin
            // fetch phase
            @(negedge clock);
            compare_word(address, m_pc, $sformatf("instr %0d fetch address", n));
            compare_word(mem_write, 32'd0, $sformatf("instr %0d mem_write in fetch", n));
            instr = prog[m_pc[5:0]];
            opc   = instr[5:0];
            ra    = instr[8:6];
            rb    = instr[11:9];
            rd    = instr[14:12];
            hl    = instr[15];
            imm   = instr[31:16];

            // execute phase
            @(negedge clock);
            if (opc == OP_STORE)
            begin
                compare_word(mem_write, 32'd1, $sformatf("instr %0d store strobe", n));
                compare_word(address, m_regs[ra], $sformatf("instr %0d store address", n));
                compare_word(data_out, m_regs[rb], $sformatf("instr %0d store data", n));
                n_store++;
            end
            else
            begin
                compare_word(mem_write, 32'd0, $sformatf("instr %0d mem_write in execute", n));
                compare_word(address, m_pc, $sformatf("instr %0d address in execute", n));
            end

            next_pc = m_pc + 32'd1;
            case (opc)
                OP_ADD: write_reg(rd, m_regs[ra] + m_regs[rb]);
                OP_SUB: write_reg(rd, m_regs[ra] - m_regs[rb]);
                OP_AND: write_reg(rd, m_regs[ra] & m_regs[rb]);
                OP_OR:  write_reg(rd, m_regs[ra] | m_regs[rb]);
                OP_XOR: write_reg(rd, m_regs[ra] ^ m_regs[rb]);
                OP_LDI:
                begin
                    if (hl)
                    begin
                        write_reg(rd, {imm, m_regs[rd][15:0]});
                    end
                    else
                    begin
                        write_reg(rd, {m_regs[rd][31:16], imm});
                    end
                end
                OP_BRF:
                begin
                    if (m_flags[ra])
                    begin
                        next_pc = {16'h0000, imm};
                        n_taken++;
                    end
                    else
                    begin
                        n_not_taken++;
                    end
                end
                default:
                begin
                    // store and undefined opcodes leave registers and flags alone
                end
            endcase

            // advance phase
            @(negedge clock);
            compare_word(mem_write, 32'd0, $sformatf("instr %0d mem_write in advance", n));
            compare_word(address, m_pc, $sformatf("instr %0d address in advance", n));
            m_pc = next_pc;
        end

        $display("%0d instructions, %0d stores, %0d branches taken, %0d not taken",
                 NUM_INSTR, n_store, n_taken, n_not_taken);
        if (error_count == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: the processor did not finish %0d instructions within %0d ns",
                 NUM_INSTR, TIMEOUT_NS);
        $display("tests failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- mcpu_top.sv
`default_nettype none
`timescale 1ns/1ps

module mcpu_top
    import mcpu_pkg::*;
(
    input  logic  clock,
    input  logic  rst_n,
    input  word_t data_in,
    output word_t address,
    output word_t data_out,
    output logic  mem_write
);

    mcpu_decode_if dec_if ();
    mcpu_result_if res_if ();

    mcpu_sequencer u_sequencer (
        .clock   (clock),
        .rst_n   (rst_n),
        .data_in (data_in),
        .dec     (dec_if.sequencer),
        .res     (res_if.sequencer)
    );

    mcpu_execute u_execute (
        .clock (clock),
        .rst_n (rst_n),
        .dec   (dec_if.execute),
        .res   (res_if.execute)
    );

    mcpu_bus u_bus (
        .dec       (dec_if.bus),
        .res       (res_if.bus),
        .address   (address),
        .data_out  (data_out),
        .mem_write (mem_write)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    localparam int CLK_HALF_NS  = 10;
    localparam int RESET_CYCLES = 5;

    initial
    begin
        clock = 1'b0;
        forever
        begin
            #(CLK_HALF_NS) clock = ~clock;
        end
    end

    // release just after the fifth rising edge
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire
